// ==== verilog/sw_pkg.sv ====
`default_nettype none

package sw_pkg;

    // nucleotide code A=0 C=1 G=2 T=3
    typedef logic [1:0] base_t;
    typedef logic signed [9:0] score_t;
    typedef logic [7:0] pos_t;
    typedef logic [7:0] byte_t;

    // leaves msb first: col, row, score high, score low
    typedef struct packed {
        pos_t               col;
        pos_t               row;
        logic signed [15:0] score;
    } sw_result_t;

    localparam score_t MATCH_SCORE    = 10'sd1;
    localparam score_t MISMATCH_SCORE = -10'sd4;
    localparam score_t GAP_OPEN       = -10'sd6;
    localparam score_t GAP_EXTEND     = -10'sd1;

    // serial port register map
    localparam logic [4:0] RX_ADDR     = 5'd0;
    localparam logic [4:0] TX_ADDR     = 5'd4;
    localparam logic [4:0] STATUS_ADDR = 5'd8;

    localparam int TX_READY_BIT = 6;
    localparam int RX_READY_BIT = 7;

    typedef enum logic [2:0] {
        S_POLL_RX,
        S_READ,
        S_CALC,
        S_POLL_TX,
        S_WRITE
    } wrap_state_e;

endpackage

`default_nettype wire

// ==== verilog/sw_pe.sv ====
`timescale 1ns/1ps
`default_nettype none

module sw_pe (
    input  logic           i_clk,
    input  logic           i_rst,
    input  logic           i_clear,
    input  sw_pkg::base_t  i_read_base,
    input  sw_pkg::base_t  i_ref_base,
    input  logic           i_ref_valid,
    input  sw_pkg::score_t i_h_diag,
    input  sw_pkg::score_t i_h_left,
    input  sw_pkg::score_t i_f_left,
    output sw_pkg::base_t  o_ref_base,
    output logic           o_ref_valid,
    output sw_pkg::score_t o_h,
    output sw_pkg::score_t o_f,
    output sw_pkg::score_t o_best,
    output sw_pkg::pos_t   o_best_col
);

    sw_pkg::base_t  read_base_q;
    sw_pkg::base_t  ref_base_q;
    logic           ref_valid_q;
    sw_pkg::score_t h_q;
    sw_pkg::score_t e_q;
    sw_pkg::score_t f_q;
    sw_pkg::score_t best_q;
    sw_pkg::pos_t   best_col_q;
    sw_pkg::pos_t   col_q;

    sw_pkg::score_t sub_score;
    sw_pkg::score_t h_match;
    sw_pkg::score_t e_next;
    sw_pkg::score_t f_next;
    sw_pkg::score_t h_next;

    function automatic sw_pkg::score_t smax(input sw_pkg::score_t a, input sw_pkg::score_t b);
        return (a > b) ? a : b;
    endfunction

    always_comb begin
        sub_score = (i_ref_base == read_base_q) ? sw_pkg::MATCH_SCORE : sw_pkg::MISMATCH_SCORE;
        h_match   = i_h_diag + sub_score;
        // gap along the reference, from this row's previous cell
        e_next    = smax(smax(h_q + sw_pkg::GAP_OPEN, e_q + sw_pkg::GAP_EXTEND), '0);
        // gap along the read, from the element above
        f_next    = smax(smax(i_h_left + sw_pkg::GAP_OPEN, i_f_left + sw_pkg::GAP_EXTEND), '0);
        h_next    = smax(smax(h_match, '0), smax(e_next, f_next));
    end

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            ref_valid_q <= 1'b0;
        end else if (i_clear) begin
            ref_valid_q <= 1'b0;
        end else begin
            ref_valid_q <= i_ref_valid;
        end
    end

    always_ff @(posedge i_clk) begin
        ref_base_q <= i_ref_base;
        if (i_clear) begin
            read_base_q <= i_read_base;
            h_q         <= '0;
            e_q         <= '0;
            f_q         <= '0;
            best_q      <= '0;
            best_col_q  <= '0;
            col_q       <= '0;
        end else if (i_ref_valid) begin
            h_q   <= h_next;
            e_q   <= e_next;
            f_q   <= f_next;
            col_q <= col_q + 1'b1;
            // strict compare keeps the earlier column on a tie
            if (h_next > best_q) begin
                best_q     <= h_next;
                best_col_q <= col_q;
            end
        end
    end

    assign o_ref_base  = ref_base_q;
    assign o_ref_valid = ref_valid_q;
    assign o_h         = h_q;
    assign o_f         = f_q;
    assign o_best      = best_q;
    assign o_best_col  = best_col_q;

endmodule

`default_nettype wire

// ==== verilog/sw_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module sw_core #(
    parameter int REF_LEN  = 16,
    parameter int READ_LEN = 16
) (
    input  logic                  avm_clk,
    input  logic                  avm_rst,
    input  logic                  i_seq_valid,
    output logic                  o_seq_ready,
    input  logic [2*REF_LEN-1:0]  i_ref_seq,
    input  logic [2*READ_LEN-1:0] i_read_seq,
    output logic                  o_res_valid,
    input  logic                  i_res_ready,
    output sw_pkg::sw_result_t    o_result
);

    // last cell leaves the chain on this count
    localparam int LAST_CYC = REF_LEN + READ_LEN - 1;
    localparam int CNT_W    = $clog2(REF_LEN + READ_LEN + 1);

    typedef enum logic [1:0] {
        C_IDLE,
        C_RUN,
        C_REDUCE,
        C_DONE
    } core_state_e;

    core_state_e          state_q;
    logic [CNT_W-1:0]     cnt_q;
    logic [2*REF_LEN-1:0] ref_sr_q;
    logic                 load;
    logic                 head_valid;
    logic                 run_last;

    sw_pkg::base_t  pe_ref_base  [READ_LEN];
    logic           pe_ref_valid [READ_LEN];
    sw_pkg::score_t pe_h         [READ_LEN];
    sw_pkg::score_t pe_f         [READ_LEN];
    sw_pkg::score_t pe_best      [READ_LEN];
    sw_pkg::pos_t   pe_best_col  [READ_LEN];

    sw_pkg::score_t red_score;
    sw_pkg::pos_t   red_row;
    sw_pkg::pos_t   red_col;
    sw_pkg::score_t best_score_q;
    sw_pkg::pos_t   best_row_q;
    sw_pkg::pos_t   best_col_q;

    assign o_seq_ready = (state_q == C_IDLE);
    assign load        = i_seq_valid && o_seq_ready;
    assign head_valid  = (state_q == C_RUN) && (cnt_q < CNT_W'(REF_LEN));
    assign run_last    = (state_q == C_RUN) && (cnt_q == CNT_W'(LAST_CYC));

    for (genvar g = 0; g < READ_LEN; g++) begin : g_pe
        sw_pkg::base_t  ref_in;
        logic           valid_in;
        sw_pkg::score_t h_up;
        sw_pkg::score_t f_up;
        sw_pkg::score_t h_diag;

        if (g == 0) begin : g_first
            // row -1 is all zero
            assign ref_in   = ref_sr_q[2*REF_LEN-1 -: 2];
            assign valid_in = head_valid;
            assign h_up     = '0;
            assign f_up     = '0;
            assign h_diag   = '0;
        end else begin : g_next
            sw_pkg::score_t h_dly_q;

            // upstream H one column back
            always_ff @(posedge avm_clk) begin
                if (load) begin
                    h_dly_q <= '0;
                end else begin
                    h_dly_q <= pe_h[g-1];
                end
            end

            assign ref_in   = pe_ref_base[g-1];
            assign valid_in = pe_ref_valid[g-1];
            assign h_up     = pe_h[g-1];
            assign f_up     = pe_f[g-1];
            assign h_diag   = h_dly_q;
        end

        sw_pe u_pe (
            .i_clk       (avm_clk),
            .i_rst       (avm_rst),
            .i_clear     (load),
            .i_read_base (i_read_seq[2*READ_LEN-1-2*g -: 2]),
            .i_ref_base  (ref_in),
            .i_ref_valid (valid_in),
            .i_h_diag    (h_diag),
            .i_h_left    (h_up),
            .i_f_left    (f_up),
            .o_ref_base  (pe_ref_base[g]),
            .o_ref_valid (pe_ref_valid[g]),
            .o_h         (pe_h[g]),
            .o_f         (pe_f[g]),
            .o_best      (pe_best[g]),
            .o_best_col  (pe_best_col[g])
        );
    end

    // lowest row wins a tie
    always_comb begin
        red_score = '0;
        red_row   = '0;
        red_col   = '0;
        for (int i = 0; i < READ_LEN; i++) begin
            if (pe_best[i] > red_score) begin
                red_score = pe_best[i];
                red_row   = sw_pkg::pos_t'(i);
                red_col   = pe_best_col[i];
            end
        end
    end

    always_ff @(posedge avm_clk or posedge avm_rst) begin
        if (avm_rst) begin
            state_q     <= C_IDLE;
            cnt_q       <= '0;
            o_res_valid <= 1'b0;
        end else begin
            case (state_q)
                C_IDLE: begin
                    if (load) begin
                        cnt_q   <= '0;
                        state_q <= C_RUN;
                    end
                end
                C_RUN: begin
                    cnt_q <= cnt_q + 1'b1;
                    if (run_last) begin
                        state_q <= C_REDUCE;
                    end
                end
                C_REDUCE: begin
                    o_res_valid <= 1'b1;
                    state_q     <= C_DONE;
                end
                C_DONE: begin
                    if (i_res_ready) begin
                        o_res_valid <= 1'b0;
                        state_q     <= C_IDLE;
                    end
                end
                default: begin
                    state_q <= C_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge avm_clk) begin
        if (load) begin
            ref_sr_q <= i_ref_seq;
        end else if (state_q == C_RUN) begin
            ref_sr_q <= ref_sr_q << 2;
        end
        if (run_last) begin
            best_score_q <= red_score;
            best_row_q   <= red_row;
            best_col_q   <= red_col;
        end
        if (state_q == C_REDUCE) begin
            o_result.col   <= best_col_q;
            o_result.row   <= best_row_q;
            o_result.score <= 16'(best_score_q);
        end
    end

endmodule

`default_nettype wire

// ==== verilog/sw_wrapper.sv ====
`timescale 1ns/1ps
`default_nettype none

module sw_wrapper #(
    parameter int REF_LEN  = 16,
    parameter int READ_LEN = 16
) (
    input  logic                  avm_clk,
    input  logic                  avm_rst,
    output logic [4:0]            o_avm_address,
    output logic                  o_avm_read,
    input  logic [31:0]           i_avm_readdata,
    output logic                  o_avm_write,
    output logic [31:0]           o_avm_writedata,
    input  logic                  i_avm_waitrequest,
    output logic                  o_seq_valid,
    input  logic                  i_seq_ready,
    output logic [2*REF_LEN-1:0]  o_ref_seq,
    output logic [2*READ_LEN-1:0] o_read_seq,
    input  logic                  i_res_valid,
    output logic                  o_res_ready,
    input  sw_pkg::sw_result_t    i_result
);

    // four bases per byte
    localparam int REF_BYTES = REF_LEN / 4;
    localparam int IN_BYTES  = (REF_LEN + READ_LEN) / 4;
    localparam int RES_W     = $bits(sw_pkg::sw_result_t);
    localparam int RES_BYTES = RES_W / 8;
    localparam int CNT_W     = $clog2(IN_BYTES + 1);

    sw_pkg::wrap_state_e  state_q;
    logic [CNT_W-1:0]     byte_cnt_q;
    logic [4:0]           addr_q;
    logic                 read_q;
    logic                 write_q;
    logic                 seq_valid_q;
    logic [2*REF_LEN-1:0] ref_q;
    logic [2*READ_LEN-1:0] rd_seq_q;
    logic [RES_W-1:0]     tx_q;

    logic                 xfer_done;
    logic                 res_take;
    sw_pkg::byte_t        rx_byte;
    sw_pkg::byte_t        tx_byte;

    assign xfer_done = (read_q || write_q) && !i_avm_waitrequest;
    assign res_take  = i_res_valid && o_res_ready;
    assign rx_byte   = i_avm_readdata[7:0];
    assign tx_byte   = tx_q[RES_W-1 -: 8];

    assign o_avm_address   = addr_q;
    assign o_avm_read      = read_q;
    assign o_avm_write     = write_q;
    assign o_avm_writedata = {24'd0, tx_byte};
    assign o_seq_valid     = seq_valid_q;
    assign o_ref_seq       = ref_q;
    assign o_read_seq      = rd_seq_q;
    // result taken once the core has the job
    assign o_res_ready     = (state_q == sw_pkg::S_CALC) && !seq_valid_q;

    always_ff @(posedge avm_clk or posedge avm_rst) begin
        if (avm_rst) begin
            state_q     <= sw_pkg::S_POLL_RX;
            byte_cnt_q  <= '0;
            addr_q      <= sw_pkg::STATUS_ADDR;
            read_q      <= 1'b1;
            write_q     <= 1'b0;
            seq_valid_q <= 1'b0;
        end else begin
            case (state_q)
                sw_pkg::S_POLL_RX: begin
                    if (xfer_done && i_avm_readdata[sw_pkg::RX_READY_BIT]) begin
                        addr_q  <= sw_pkg::RX_ADDR;
                        state_q <= sw_pkg::S_READ;
                    end
                end
                sw_pkg::S_READ: begin
                    if (xfer_done) begin
                        if (byte_cnt_q == CNT_W'(IN_BYTES - 1)) begin
                            byte_cnt_q  <= '0;
                            read_q      <= 1'b0;
                            seq_valid_q <= 1'b1;
                            state_q     <= sw_pkg::S_CALC;
                        end else begin
                            byte_cnt_q <= byte_cnt_q + 1'b1;
                            addr_q     <= sw_pkg::STATUS_ADDR;
                            state_q    <= sw_pkg::S_POLL_RX;
                        end
                    end
                end
                sw_pkg::S_CALC: begin
                    if (seq_valid_q && i_seq_ready) begin
                        seq_valid_q <= 1'b0;
                    end
                    if (res_take) begin
                        read_q  <= 1'b1;
                        addr_q  <= sw_pkg::STATUS_ADDR;
                        state_q <= sw_pkg::S_POLL_TX;
                    end
                end
                sw_pkg::S_POLL_TX: begin
                    if (xfer_done && i_avm_readdata[sw_pkg::TX_READY_BIT]) begin
                        read_q  <= 1'b0;
                        write_q <= 1'b1;
                        addr_q  <= sw_pkg::TX_ADDR;
                        state_q <= sw_pkg::S_WRITE;
                    end
                end
                sw_pkg::S_WRITE: begin
                    if (xfer_done) begin
                        write_q <= 1'b0;
                        read_q  <= 1'b1;
                        addr_q  <= sw_pkg::STATUS_ADDR;
                        if (byte_cnt_q == CNT_W'(RES_BYTES - 1)) begin
                            // job done, back to waiting for input
                            byte_cnt_q <= '0;
                            state_q    <= sw_pkg::S_POLL_RX;
                        end else begin
                            byte_cnt_q <= byte_cnt_q + 1'b1;
                            state_q    <= sw_pkg::S_POLL_TX;
                        end
                    end
                end
                default: begin
                    state_q <= sw_pkg::S_POLL_RX;
                end
            endcase
        end
    end

    // sequence and result shift registers
    always_ff @(posedge avm_clk) begin
        if (state_q == sw_pkg::S_READ && xfer_done) begin
            if (byte_cnt_q < CNT_W'(REF_BYTES)) begin
                ref_q <= (ref_q << 8) | (2*REF_LEN)'(rx_byte);
            end else begin
                rd_seq_q <= (rd_seq_q << 8) | (2*READ_LEN)'(rx_byte);
            end
        end
        if (res_take) begin
            tx_q <= i_result;
        end else if (state_q == sw_pkg::S_WRITE && xfer_done) begin
            tx_q <= tx_q << 8;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/sw_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module sw_top #(
    parameter int REF_LEN  = 16,
    parameter int READ_LEN = 16
) (
    input  logic        avm_clk,
    input  logic        avm_rst,
    output logic [4:0]  o_avm_address,
    output logic        o_avm_read,
    input  logic [31:0] i_avm_readdata,
    output logic        o_avm_write,
    output logic [31:0] o_avm_writedata,
    input  logic        i_avm_waitrequest
);

    logic                  seq_valid;
    logic                  seq_ready;
    logic [2*REF_LEN-1:0]  ref_seq;
    logic [2*READ_LEN-1:0] read_seq;
    logic                  res_valid;
    logic                  res_ready;
    sw_pkg::sw_result_t    result;

    sw_wrapper #(
        .REF_LEN  (REF_LEN),
        .READ_LEN (READ_LEN)
    ) u_wrapper (
        .avm_clk           (avm_clk),
        .avm_rst           (avm_rst),
        .o_avm_address     (o_avm_address),
        .o_avm_read        (o_avm_read),
        .i_avm_readdata    (i_avm_readdata),
        .o_avm_write       (o_avm_write),
        .o_avm_writedata   (o_avm_writedata),
        .i_avm_waitrequest (i_avm_waitrequest),
        .o_seq_valid       (seq_valid),
        .i_seq_ready       (seq_ready),
        .o_ref_seq         (ref_seq),
        .o_read_seq        (read_seq),
        .i_res_valid       (res_valid),
        .o_res_ready       (res_ready),
        .i_result          (result)
    );

    sw_core #(
        .REF_LEN  (REF_LEN),
        .READ_LEN (READ_LEN)
    ) u_core (
        .avm_clk     (avm_clk),
        .avm_rst     (avm_rst),
        .i_seq_valid (seq_valid),
        .o_seq_ready (seq_ready),
        .i_ref_seq   (ref_seq),
        .i_read_seq  (read_seq),
        .o_res_valid (res_valid),
        .i_res_ready (res_ready),
        .o_result    (result)
    );

endmodule

`default_nettype wire

// ==== verification/sw_props.sv ====
`timescale 1ns/1ps
`default_nettype none

module sw_props (
    input logic        avm_clk,
    input logic        avm_rst,
    input logic [4:0]  i_address,
    input logic        i_read,
    input logic        i_write,
    input logic [31:0] i_readdata,
    input logic        i_waitrequest
);

    logic done;
    logic rx_seen_q;

    assign done = (i_read || i_write) && !i_waitrequest;

    // rx bit from the latest completed status read
    always_ff @(posedge avm_clk or posedge avm_rst) begin
        if (avm_rst) begin
            rx_seen_q <= 1'b0;
        end else if (done && i_read && i_address == sw_pkg::STATUS_ADDR) begin
            rx_seen_q <= i_readdata[sw_pkg::RX_READY_BIT];
        end else if (done && i_read && i_address == sw_pkg::RX_ADDR) begin
            rx_seen_q <= 1'b0;
        end
    end

    a_one_dir: assert property (@(posedge avm_clk) disable iff (avm_rst)
        !(i_read && i_write))
        else $error("read and write high in the same cycle");

    a_hold: assert property (@(posedge avm_clk) disable iff (avm_rst)
        (i_read || i_write) && i_waitrequest |=>
        $stable(i_address) && $stable(i_read) && $stable(i_write))
        else $error("request changed during waitrequest");

    a_tx_only: assert property (@(posedge avm_clk) disable iff (avm_rst)
        i_write |-> i_address == sw_pkg::TX_ADDR)
        else $error("write to an address other than the transmit register");

    a_rx_gate: assert property (@(posedge avm_clk) disable iff (avm_rst)
        i_read && i_address == sw_pkg::RX_ADDR |-> rx_seen_q)
        else $error("receive read without a status read showing data");

endmodule

bind sw_wrapper sw_props u_props (
    .avm_clk       (avm_clk),
    .avm_rst       (avm_rst),
    .i_address     (o_avm_address),
    .i_read        (o_avm_read),
    .i_write       (o_avm_write),
    .i_readdata    (i_avm_readdata),
    .i_waitrequest (i_avm_waitrequest)
);

`default_nettype wire

// ==== verification/sw_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module sw_tb;

    localparam int REF_LEN     = 16;
    localparam int READ_LEN    = 16;
    localparam int REF_BYTES   = REF_LEN / 4;
    localparam int READ_BYTES  = READ_LEN / 4;
    localparam int RST_CYCLES  = 10;
    localparam int JOB_TIMEOUT = 20000;
    // affine scoring
    localparam int SC_MATCH    = 1;
    localparam int SC_MISMATCH = -4;
    localparam int SC_OPEN     = -6;
    localparam int SC_EXTEND   = -1;

    logic        avm_clk = 1'b0;
    logic        avm_rst = 1'b1;
    logic [4:0]  avm_address;
    logic        avm_read;
    logic [31:0] avm_readdata = 32'd0;
    logic        avm_write;
    logic [31:0] avm_writedata;
    logic        avm_waitrequest = 1'b1;

    integer seed = 32'h48c10fa0;
    int     value_errors = 0;
    int     proto_errors = 0;
    int     timeouts = 0;
    bit     timed_out = 1'b0;
    int     rst_cnt = 0;

    // serial port slave state
    sw_pkg::byte_t rx_fifo[$];
    sw_pkg::byte_t tx_fifo[$];
    logic          rx_rdy = 1'b0;
    logic          tx_rdy = 1'b0;
    int            rx_delay = 0;
    int            tx_delay = 0;
    int            wait_pct = 30;
    int            max_delay = 6;
    logic          acc_read = 1'b0;
    logic          acc_write = 1'b0;
    logic [4:0]    acc_addr = '0;
    sw_pkg::byte_t acc_byte = '0;

    int mh [READ_LEN+1][REF_LEN+1];
    int me [READ_LEN+1][REF_LEN+1];
    int mf [READ_LEN+1][REF_LEN+1];

    sw_top #(
        .REF_LEN  (REF_LEN),
        .READ_LEN (READ_LEN)
    ) dut (
        .avm_clk           (avm_clk),
        .avm_rst           (avm_rst),
        .o_avm_address     (avm_address),
        .o_avm_read        (avm_read),
        .i_avm_readdata    (avm_readdata),
        .o_avm_write       (avm_write),
        .o_avm_writedata   (avm_writedata),
        .i_avm_waitrequest (avm_waitrequest)
    );

    initial begin
        forever #50 avm_clk = ~avm_clk;
    end

    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    function automatic logic [511:0] random_seq(input int n);
        logic [511:0] s;
        s = '0;
        for (int i = 0; i < n; i++) begin
            s[2*i +: 2] = 2'(rand_below(4));
        end
        return s;
    endfunction

    function automatic int max3(input int a, input int b, input int c);
        int m;
        m = (a > b) ? a : b;
        return (m > c) ? m : c;
    endfunction

    // full affine matrix where the first maximum in row-major order wins
    function automatic sw_pkg::sw_result_t score_model(input logic [2*REF_LEN-1:0] rseq,
                                                      input logic [2*READ_LEN-1:0] qseq);
        sw_pkg::sw_result_t res;
        int best;
        int sub;
        res  = '0;
        best = 0;
        for (int i = 0; i <= READ_LEN; i++) begin
            for (int j = 0; j <= REF_LEN; j++) begin
                mh[i][j] = 0;
                me[i][j] = 0;
                mf[i][j] = 0;
            end
        end
        for (int i = 1; i <= READ_LEN; i++) begin
            for (int j = 1; j <= REF_LEN; j++) begin
                sub = (rseq[2*REF_LEN-2*j +: 2] == qseq[2*READ_LEN-2*i +: 2]) ?
                      SC_MATCH : SC_MISMATCH;
                me[i][j] = max3(0, mh[i][j-1] + SC_OPEN, me[i][j-1] + SC_EXTEND);
                mf[i][j] = max3(0, mh[i-1][j] + SC_OPEN, mf[i-1][j] + SC_EXTEND);
                mh[i][j] = max3(mh[i-1][j-1] + sub, me[i][j], mf[i][j]);
                if (mh[i][j] > best) begin
                    best    = mh[i][j];
                    res.row = sw_pkg::pos_t'(i - 1);
                    res.col = sw_pkg::pos_t'(j - 1);
                end
            end
        end
        res.score = 16'(best);
        return res;
    endfunction

    function automatic logic [31:0] slave_readdata(input logic [4:0] addr);
        if (addr == sw_pkg::STATUS_ADDR) begin
            return {24'd0, rx_rdy, tx_rdy, 6'd0};
        end else if (addr == sw_pkg::RX_ADDR && rx_fifo.size() > 0) begin
            return {24'd0, rx_fifo[0]};
        end
        return 32'd0;
    endfunction

    task automatic check_byte(input string name, input sw_pkg::byte_t got,
                              input sw_pkg::byte_t exp);
        if (got !== exp) begin
            $display("FAILED %s: got 0x%02h expected 0x%02h", name, got, exp);
            value_errors++;
        end
    endtask

    task automatic check_result(input string name, input sw_pkg::sw_result_t got,
                                input sw_pkg::sw_result_t exp);
        if (got.col !== exp.col) begin
            $display("FAILED %s.col: got 0x%02h expected 0x%02h", name, got.col, exp.col);
            value_errors++;
        end
        if (got.row !== exp.row) begin
            $display("FAILED %s.row: got 0x%02h expected 0x%02h", name, got.row, exp.row);
            value_errors++;
        end
        if (got.score !== exp.score) begin
            $display("FAILED %s.score: got 0x%04h expected 0x%04h", name, got.score, exp.score);
            value_errors++;
        end
    endtask

    task automatic run_job(input string tag, input logic [2*REF_LEN-1:0] rseq,
                           input logic [2*READ_LEN-1:0] qseq, input sw_pkg::sw_result_t exp);
        sw_pkg::byte_t      exp_bytes[4];
        sw_pkg::sw_result_t got;
        int                 cyc;
        if (!timed_out) begin
            @(posedge avm_clk);
            for (int k = 0; k < REF_BYTES; k++) begin
                rx_fifo.push_back(rseq[2*REF_LEN-1-8*k -: 8]);
            end
            for (int k = 0; k < READ_BYTES; k++) begin
                rx_fifo.push_back(qseq[2*READ_LEN-1-8*k -: 8]);
            end
            cyc = 0;
            while (tx_fifo.size() < 4 && cyc < JOB_TIMEOUT) begin
                @(posedge avm_clk);
                cyc++;
            end
            if (tx_fifo.size() < 4) begin
                $display("%s: timeout, only %0d of 4 result bytes after %0d cycles",
                         tag, tx_fifo.size(), cyc);
                timeouts++;
                timed_out = 1'b1;
            end else begin
                exp_bytes[0] = exp.col;
                exp_bytes[1] = exp.row;
                exp_bytes[2] = exp.score[15:8];
                exp_bytes[3] = exp.score[7:0];
                for (int k = 0; k < 4; k++) begin
                    check_byte($sformatf("%s o_avm_writedata byte %0d", tag, k),
                               tx_fifo[k], exp_bytes[k]);
                end
                got = {tx_fifo[0], tx_fifo[1], tx_fifo[2], tx_fifo[3]};
                check_result($sformatf("%s o_result", tag), got, exp);
                if (rx_fifo.size() != 0) begin
                    $display("%s: %0d input bytes were never read", tag, rx_fifo.size());
                    proto_errors++;
                end
                tx_fifo.delete();
            end
        end
    endtask

    // reset sequencer and serial port slave on the falling edge
    always @(negedge avm_clk) begin
        if (rst_cnt < RST_CYCLES) begin
            rst_cnt++;
            avm_rst = (rst_cnt < RST_CYCLES);
            avm_waitrequest = 1'b1;
        end else begin
            // effects of the transfer that completed on the last rising edge
            if (acc_read && acc_addr == sw_pkg::RX_ADDR) begin
                if (rx_fifo.size() == 0) begin
                    $display("slave: receive register read while empty");
                    proto_errors++;
                end else begin
                    void'(rx_fifo.pop_front());
                end
                rx_rdy   = 1'b0;
                rx_delay = rand_below(max_delay + 1);
            end
            if (acc_write) begin
                if (acc_addr == sw_pkg::TX_ADDR) begin
                    tx_fifo.push_back(acc_byte);
                end else begin
                    $display("slave: write to address %0d", acc_addr);
                    proto_errors++;
                end
                tx_rdy   = 1'b0;
                tx_delay = rand_below(max_delay + 1);
            end
            if (!rx_rdy && rx_fifo.size() > 0) begin
                if (rx_delay == 0) begin
                    rx_rdy = 1'b1;
                end else begin
                    rx_delay--;
                end
            end
            if (!tx_rdy) begin
                if (tx_delay == 0) begin
                    tx_rdy = 1'b1;
                end else begin
                    tx_delay--;
                end
            end
            acc_read     = 1'b0;
            acc_write    = 1'b0;
            avm_readdata = $random(seed);
            avm_waitrequest = (rand_below(100) < wait_pct);
            if ((avm_read || avm_write) && !avm_waitrequest) begin
                acc_read  = avm_read;
                acc_write = avm_write;
                acc_addr  = avm_address;
                acc_byte  = avm_writedata[7:0];
                if (avm_read) begin
                    avm_readdata = slave_readdata(avm_address);
                end
            end
        end
    end

    initial begin
        logic [2*REF_LEN-1:0]  rseq;
        logic [2*READ_LEN-1:0] qseq;
        sw_pkg::sw_result_t    exp;
        int                    cyc;
        int                    k;
        cyc = 0;
        while (avm_rst && cyc < 4 * RST_CYCLES) begin
            @(posedge avm_clk);
            cyc++;
        end
        if (avm_rst) begin
            $display("reset never released");
            timeouts++;
            timed_out = 1'b1;
        end

        rseq = (2*REF_LEN)'(random_seq(REF_LEN));
        for (int i = 0; i < READ_LEN; i++) begin
            qseq[2*READ_LEN-1-2*i -: 2] = rseq[2*REF_LEN-1-2*i -: 2];
        end
        exp.col   = sw_pkg::pos_t'(REF_LEN - 1);
        exp.row   = sw_pkg::pos_t'(READ_LEN - 1);
        exp.score = 16'(REF_LEN);
        run_job("identical", rseq, qseq, exp);

        // all A against all G
        rseq = '0;
        qseq = {READ_LEN{2'b10}};
        exp  = '0;
        run_job("no match", rseq, qseq, exp);

        rseq = (2*REF_LEN)'(random_seq(REF_LEN));
        for (int i = 0; i < READ_LEN; i++) begin
            qseq[2*READ_LEN-1-2*i -: 2] = rseq[2*REF_LEN-1-2*i -: 2];
        end
        qseq[2*READ_LEN-1-10 -: 2] = ~qseq[2*READ_LEN-1-10 -: 2];
        run_job("mismatch", rseq, qseq, score_model(rseq, qseq));

        // read skips one reference base halfway and misses on its first base
        rseq = (2*REF_LEN)'(random_seq(REF_LEN));
        for (int i = 0; i < READ_LEN; i++) begin
            k = (i < READ_LEN / 2) ? i : i + 1;
            if (k < REF_LEN) begin
                qseq[2*READ_LEN-1-2*i -: 2] = rseq[2*REF_LEN-1-2*k -: 2];
            end else begin
                qseq[2*READ_LEN-1-2*i -: 2] = 2'(rand_below(4));
            end
        end
        qseq[2*READ_LEN-1 -: 2] = ~qseq[2*READ_LEN-1 -: 2];
        run_job("gap", rseq, qseq, score_model(rseq, qseq));

        for (int n = 0; n < 12; n++) begin
            if (n == 6) begin
                wait_pct  = 85;
                max_delay = 40;
            end
            rseq = (2*REF_LEN)'(random_seq(REF_LEN));
            qseq = (2*READ_LEN)'(random_seq(READ_LEN));
            run_job($sformatf("random %0d", n), rseq, qseq, score_model(rseq, qseq));
        end

        // nothing more may leave the port
        repeat (200) @(posedge avm_clk);
        if (tx_fifo.size() != 0 || rx_fifo.size() != 0) begin
            $display("extra activity after the last job: %0d bytes sent, %0d unread",
                     tx_fifo.size(), rx_fifo.size());
            proto_errors++;
        end
        $display("errors: %0d value, %0d protocol, %0d timeout",
                 value_errors, proto_errors, timeouts);
        if (value_errors + proto_errors + timeouts == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sources.f ====
verilog/sw_pkg.sv
verilog/sw_pe.sv
verilog/sw_core.sv
verilog/sw_wrapper.sv
verilog/sw_top.sv
verification/sw_props.sv
verification/sw_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module sw_tb -f sources.f -o sw_sim

status=0
./obj_dir/sw_sim > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "Finished with errors" sim.log; then
    echo "simulation FAILED"
    exit 1
fi
echo "simulation passed"
